/* hdl/axi_adapter_pkg.sv */
// geometry is fixed to 64-bit words and 32-byte lines, one AXI data beat per word
// line bursts always start at the line base, so wrapping bursts are never issued
package axi_adapter_pkg;

  // ------------------------------
  // word and line geometry
  // ------------------------------
  localparam int unsigned XLEN           = 64;
  localparam int unsigned LINE_WIDTH     = 256;
  localparam int unsigned WORDS_PER_LINE = LINE_WIDTH / XLEN;
  localparam int unsigned BURST_LEN      = WORDS_PER_LINE - 1;
  localparam int unsigned WORD_IDX_W     = $clog2(WORDS_PER_LINE);
  localparam int unsigned LINE_OFFSET_W  = $clog2(LINE_WIDTH / 8);
  localparam int unsigned ID_W           = 4;

  // ------------------------------
  // AXI encodings
  // ------------------------------
  localparam logic [1:0] AXI_BURST_INCR = 2'b01;
  // beat size of a full word, used for every line burst
  localparam logic [2:0] AXI_SIZE_WORD  = 3'($clog2(XLEN / 8));

  typedef logic [XLEN-1:0]                         addr_t;
  typedef logic [XLEN-1:0]                         word_t;
  typedef logic [XLEN/8-1:0]                       strb_t;
  typedef logic [WORDS_PER_LINE-1:0][XLEN-1:0]     line_t;
  typedef logic [WORDS_PER_LINE-1:0][XLEN/8-1:0]   line_strb_t;
  typedef logic [ID_W-1:0]                         id_t;
  typedef logic [WORD_IDX_W-1:0]                   word_idx_t;

  // single word or whole cache line
  typedef enum logic {
    REQ_SINGLE = 1'b0,
    REQ_LINE   = 1'b1
  } req_kind_e;

  // base address of the line that holds addr
  function automatic addr_t line_base(addr_t addr);
    return {addr[XLEN-1:LINE_OFFSET_W], {LINE_OFFSET_W{1'b0}}};
  endfunction

  // index of the addressed word inside its line
  function automatic word_idx_t word_index(addr_t addr);
    return addr[LINE_OFFSET_W-1 -: WORD_IDX_W];
  endfunction

endpackage

/* hdl/axi_line_writer.sv */
// single writes take data and strobes from word 0; request fields must hold until gnt_o
// bresp is not checked, every B beat completes the write
`timescale 1ns/1ps

module axi_line_writer (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        req_i,
  output logic                        idle_o,
  input  axi_adapter_pkg::req_kind_e  kind_i,
  input  axi_adapter_pkg::addr_t      addr_i,
  input  axi_adapter_pkg::line_t      wdata_i,
  input  axi_adapter_pkg::line_strb_t be_i,
  input  logic [1:0]                  size_i,
  input  axi_adapter_pkg::id_t        id_i,
  output logic                        gnt_o,
  output logic                        valid_o,
  output axi_adapter_pkg::id_t        id_o,
  // write address channel
  output logic                        awvalid_o,
  input  logic                        awready_i,
  output axi_adapter_pkg::addr_t      awaddr_o,
  output logic [7:0]                  awlen_o,
  output logic [2:0]                  awsize_o,
  output logic [1:0]                  awburst_o,
  output axi_adapter_pkg::id_t        awid_o,
  // write data channel
  output logic                        wvalid_o,
  input  logic                        wready_i,
  output axi_adapter_pkg::word_t      wdata_o,
  output axi_adapter_pkg::strb_t      wstrb_o,
  output logic                        wlast_o,
  // write response channel
  input  logic                        bvalid_i,
  input  axi_adapter_pkg::id_t        bid_i,
  output logic                        bready_o
);
  import axi_adapter_pkg::*;

  typedef enum logic [2:0] {
    W_IDLE,
    W_WAIT_AW,
    W_WAIT_LAST_W,
    W_WAIT_LAST_W_AW,
    W_WAIT_AW_BURST,
    W_WAIT_B
  } wr_state_e;

  wr_state_e state_q, state_d;
  // index of the next word of the line to put on W
  word_idx_t beat_q, beat_d;
  logic      is_line;
  logic      last_beat;

  assign is_line   = (kind_i == REQ_LINE);
  assign last_beat = !is_line || (beat_q == word_idx_t'(BURST_LEN));
  assign idle_o    = (state_q == W_IDLE);

  // ------------------------------
  // channel payloads
  // ------------------------------
  assign awaddr_o  = is_line ? line_base(addr_i) : addr_i;
  assign awlen_o   = is_line ? 8'(BURST_LEN) : 8'd0;
  assign awsize_o  = is_line ? AXI_SIZE_WORD : {1'b0, size_i};
  assign awburst_o = AXI_BURST_INCR;
  assign awid_o    = id_i;

  assign wdata_o = wdata_i[beat_q];
  assign wstrb_o = be_i[beat_q];
  assign wlast_o = last_beat;

  // the slave echoes the request ID on B
  assign id_o = bid_i;

  // ------------------------------
  // write FSM
  // ------------------------------
  always_comb begin
    state_d   = state_q;
    beat_d    = beat_q;
    awvalid_o = 1'b0;
    wvalid_o  = 1'b0;
    bready_o  = 1'b0;
    gnt_o     = 1'b0;
    valid_o   = 1'b0;

    case (state_q)
      W_IDLE: begin
        if (req_i) begin
          awvalid_o = 1'b1;
          wvalid_o  = 1'b1;
          if (!is_line) begin
            gnt_o = awready_i & wready_i;
            case ({awready_i, wready_i})
              2'b11:   state_d = W_WAIT_B;
              2'b10:   state_d = W_WAIT_LAST_W;
              2'b01:   state_d = W_WAIT_AW;
              default: state_d = W_IDLE;
            endcase
          end else begin
            // first word of the burst goes out with AW
            if (wready_i) begin
              beat_d = beat_q + 1'b1;
            end
            case ({awready_i, wready_i})
              2'b11, 2'b10: state_d = W_WAIT_LAST_W;
              2'b01:        state_d = W_WAIT_LAST_W_AW;
              default:      state_d = W_IDLE;
            endcase
          end
        end
      end

      // single write, data already taken
      W_WAIT_AW: begin
        awvalid_o = 1'b1;
        if (awready_i) begin
          gnt_o   = 1'b1;
          state_d = W_WAIT_B;
        end
      end

      // address taken, words still outstanding
      W_WAIT_LAST_W: begin
        wvalid_o = 1'b1;
        if (wready_i) begin
          if (last_beat) begin
            gnt_o   = 1'b1;
            beat_d  = '0;
            state_d = W_WAIT_B;
          end else begin
            beat_d = beat_q + 1'b1;
          end
        end
      end

      // line burst with neither AW nor the last word taken yet
      W_WAIT_LAST_W_AW: begin
        awvalid_o = 1'b1;
        wvalid_o  = 1'b1;
        if (wready_i) begin
          beat_d = last_beat ? '0 : beat_q + 1'b1;
        end
        case ({awready_i, wready_i})
          2'b11: begin
            gnt_o   = last_beat;
            state_d = last_beat ? W_WAIT_B : W_WAIT_LAST_W;
          end
          2'b10: state_d = W_WAIT_LAST_W;
          2'b01: begin
            if (last_beat) begin
              state_d = W_WAIT_AW_BURST;
            end
          end
          default: state_d = W_WAIT_LAST_W_AW;
        endcase
      end

      // all words sent, address still pending
      W_WAIT_AW_BURST: begin
        awvalid_o = 1'b1;
        if (awready_i) begin
          gnt_o   = 1'b1;
          state_d = W_WAIT_B;
        end
      end

      W_WAIT_B: begin
        bready_o = 1'b1;
        if (bvalid_i) begin
          valid_o = 1'b1;
          state_d = W_IDLE;
        end
      end

      default: state_d = W_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= W_IDLE;
      beat_q  <= '0;
    end else begin
      state_q <= state_d;
      beat_q  <= beat_d;
    end
  end

endmodule

/* hdl/axi_line_reader.sv */
// line reads start at the line base and fill the line register in beat order
// single reads return their word in word 0 of rdata_o, the other words are stale
`timescale 1ns/1ps

module axi_line_reader (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       req_i,
  output logic                       idle_o,
  input  axi_adapter_pkg::req_kind_e kind_i,
  input  axi_adapter_pkg::addr_t     addr_i,
  input  logic [1:0]                 size_i,
  input  axi_adapter_pkg::id_t       id_i,
  output logic                       gnt_o,
  output logic                       valid_o,
  output axi_adapter_pkg::line_t     rdata_o,
  output axi_adapter_pkg::id_t       id_o,
  // strobe for the requested word of a line read
  output axi_adapter_pkg::word_t     critical_word_o,
  output logic                       critical_word_valid_o,
  // read address channel
  output logic                       arvalid_o,
  input  logic                       arready_i,
  output axi_adapter_pkg::addr_t     araddr_o,
  output logic [7:0]                 arlen_o,
  output logic [2:0]                 arsize_o,
  output logic [1:0]                 arburst_o,
  output axi_adapter_pkg::id_t       arid_o,
  // read data channel
  input  logic                       rvalid_i,
  input  axi_adapter_pkg::word_t     rdata_i,
  input  axi_adapter_pkg::id_t       rid_i,
  input  logic                       rlast_i,
  output logic                       rready_o
);
  import axi_adapter_pkg::*;

  typedef enum logic [1:0] {
    R_IDLE,
    R_WAIT_R_SINGLE,
    R_WAIT_R_LINE,
    R_COMPLETE
  } rd_state_e;

  rd_state_e state_q, state_d;
  // slot of the next incoming beat
  word_idx_t cnt_q, cnt_d;
  // requested word within the line, taken at grant
  word_idx_t offset_q, offset_d;
  line_t     line_q;
  id_t       id_q;
  logic      is_line;
  logic      r_fire;

  assign is_line = (kind_i == REQ_LINE);
  assign r_fire  = rvalid_i & rready_o;
  assign idle_o  = (state_q == R_IDLE);

  // ------------------------------
  // AR payload
  // ------------------------------
  assign araddr_o  = is_line ? line_base(addr_i) : addr_i;
  assign arlen_o   = is_line ? 8'(BURST_LEN) : 8'd0;
  assign arsize_o  = is_line ? AXI_SIZE_WORD : {1'b0, size_i};
  assign arburst_o = AXI_BURST_INCR;
  assign arid_o    = id_i;

  // response side
  assign rdata_o         = line_q;
  assign id_o            = id_q;
  assign critical_word_o = rdata_i;

  // ------------------------------
  // read FSM
  // ------------------------------
  always_comb begin
    state_d               = state_q;
    cnt_d                 = cnt_q;
    offset_d              = offset_q;
    arvalid_o             = 1'b0;
    rready_o              = 1'b0;
    gnt_o                 = 1'b0;
    valid_o               = 1'b0;
    critical_word_valid_o = 1'b0;

    case (state_q)
      R_IDLE: begin
        if (req_i) begin
          arvalid_o = 1'b1;
          gnt_o     = arready_i;
          if (arready_i) begin
            cnt_d    = '0;
            offset_d = word_index(addr_i);
            state_d  = is_line ? R_WAIT_R_LINE : R_WAIT_R_SINGLE;
          end
        end
      end

      R_WAIT_R_SINGLE, R_WAIT_R_LINE: begin
        rready_o = 1'b1;
        if (rvalid_i) begin
          // the beat matching the request offset is the critical word
          if (state_q == R_WAIT_R_LINE && cnt_q == offset_q) begin
            critical_word_valid_o = 1'b1;
          end
          cnt_d = cnt_q + 1'b1;
          if (rlast_i) begin
            state_d = R_COMPLETE;
          end
        end
      end

      // line register now holds every beat
      R_COMPLETE: begin
        valid_o = 1'b1;
        state_d = R_IDLE;
      end

      default: state_d = R_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q  <= R_IDLE;
      cnt_q    <= '0;
      offset_q <= '0;
    end else begin
      state_q  <= state_d;
      cnt_q    <= cnt_d;
      offset_q <= offset_d;
    end
  end

  // line assembly and response ID
  always_ff @(posedge clk_i) begin
    if (r_fire) begin
      line_q[cnt_q] <= rdata_i;
      if (rlast_i) begin
        id_q <= rid_i;
      end
    end
  end

endmodule

/* hdl/axi_cache_adapter.sv */
// one transaction in flight; a new request waits until both engines are idle
// the requester holds req_i and its fields until gnt_o and waits for valid_o before the next
`timescale 1ns/1ps

module axi_cache_adapter (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  // request side
  input  logic                        req_i,
  input  axi_adapter_pkg::req_kind_e  kind_i,
  input  axi_adapter_pkg::addr_t      addr_i,
  input  logic                        we_i,
  input  axi_adapter_pkg::line_t      wdata_i,
  input  axi_adapter_pkg::line_strb_t be_i,
  input  logic [1:0]                  size_i,
  input  axi_adapter_pkg::id_t        id_i,
  output logic                        gnt_o,
  // response side
  output logic                        valid_o,
  output axi_adapter_pkg::line_t      rdata_o,
  output axi_adapter_pkg::id_t        id_o,
  output axi_adapter_pkg::word_t      critical_word_o,
  output logic                        critical_word_valid_o,
  // AXI AW
  output logic                        awvalid_o,
  input  logic                        awready_i,
  output axi_adapter_pkg::addr_t      awaddr_o,
  output logic [7:0]                  awlen_o,
  output logic [2:0]                  awsize_o,
  output logic [1:0]                  awburst_o,
  output axi_adapter_pkg::id_t        awid_o,
  // AXI W
  output logic                        wvalid_o,
  input  logic                        wready_i,
  output axi_adapter_pkg::word_t      wdata_o,
  output axi_adapter_pkg::strb_t      wstrb_o,
  output logic                        wlast_o,
  // AXI B
  input  logic                        bvalid_i,
  input  axi_adapter_pkg::id_t        bid_i,
  output logic                        bready_o,
  // AXI AR
  output logic                        arvalid_o,
  input  logic                        arready_i,
  output axi_adapter_pkg::addr_t      araddr_o,
  output logic [7:0]                  arlen_o,
  output logic [2:0]                  arsize_o,
  output logic [1:0]                  arburst_o,
  output axi_adapter_pkg::id_t        arid_o,
  // AXI R
  input  logic                        rvalid_i,
  input  axi_adapter_pkg::word_t      rdata_i,
  input  axi_adapter_pkg::id_t        rid_i,
  input  logic                        rlast_i,
  output logic                        rready_o
);
  import axi_adapter_pkg::*;

  logic  wr_req, wr_idle, wr_gnt, wr_valid;
  logic  rd_req, rd_idle, rd_gnt, rd_valid;
  logic  both_idle;
  id_t   wr_id, rd_id;
  line_t rd_line;

  // ------------------------------
  // request steering
  // ------------------------------
  assign both_idle = wr_idle & rd_idle;
  assign wr_req    = req_i & we_i & both_idle;
  assign rd_req    = req_i & ~we_i & both_idle;

  // only one engine is ever active, so plain OR merges are safe
  assign gnt_o   = wr_gnt | rd_gnt;
  assign valid_o = wr_valid | rd_valid;
  assign id_o    = rd_valid ? rd_id : wr_id;
  // write responses carry no data
  assign rdata_o = rd_valid ? rd_line : '0;

  axi_line_writer u_writer (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .req_i     (wr_req),
    .idle_o    (wr_idle),
    .kind_i    (kind_i),
    .addr_i    (addr_i),
    .wdata_i   (wdata_i),
    .be_i      (be_i),
    .size_i    (size_i),
    .id_i      (id_i),
    .gnt_o     (wr_gnt),
    .valid_o   (wr_valid),
    .id_o      (wr_id),
    .awvalid_o (awvalid_o),
    .awready_i (awready_i),
    .awaddr_o  (awaddr_o),
    .awlen_o   (awlen_o),
    .awsize_o  (awsize_o),
    .awburst_o (awburst_o),
    .awid_o    (awid_o),
    .wvalid_o  (wvalid_o),
    .wready_i  (wready_i),
    .wdata_o   (wdata_o),
    .wstrb_o   (wstrb_o),
    .wlast_o   (wlast_o),
    .bvalid_i  (bvalid_i),
    .bid_i     (bid_i),
    .bready_o  (bready_o)
  );

  axi_line_reader u_reader (
    .clk_i                 (clk_i),
    .rst_ni                (rst_ni),
    .req_i                 (rd_req),
    .idle_o                (rd_idle),
    .kind_i                (kind_i),
    .addr_i                (addr_i),
    .size_i                (size_i),
    .id_i                  (id_i),
    .gnt_o                 (rd_gnt),
    .valid_o               (rd_valid),
    .rdata_o               (rd_line),
    .id_o                  (rd_id),
    .critical_word_o       (critical_word_o),
    .critical_word_valid_o (critical_word_valid_o),
    .arvalid_o             (arvalid_o),
    .arready_i             (arready_i),
    .araddr_o              (araddr_o),
    .arlen_o               (arlen_o),
    .arsize_o              (arsize_o),
    .arburst_o             (arburst_o),
    .arid_o                (arid_o),
    .rvalid_i              (rvalid_i),
    .rdata_i               (rdata_i),
    .rid_i                 (rid_i),
    .rlast_i               (rlast_i),
    .rready_o              (rready_o)
  );

endmodule

/* tb/axi_mem_slave.sv */
// behavioral AXI4 memory of 64 words, addresses above bit 8 are ignored
// one write and one read burst at a time, bursts of at most four beats
`timescale 1ns/1ps

module axi_mem_slave (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  // one stall bit per channel: AW, W, B, AR, R
  input  logic [4:0]             stall_i,
  input  logic                   awvalid_i,
  output logic                   awready_o,
  input  axi_adapter_pkg::addr_t awaddr_i,
  input  logic [7:0]             awlen_i,
  input  axi_adapter_pkg::id_t   awid_i,
  input  logic                   wvalid_i,
  output logic                   wready_o,
  input  axi_adapter_pkg::word_t wdata_i,
  input  axi_adapter_pkg::strb_t wstrb_i,
  input  logic                   wlast_i,
  output logic                   bvalid_o,
  input  logic                   bready_i,
  output axi_adapter_pkg::id_t   bid_o,
  input  logic                   arvalid_i,
  output logic                   arready_o,
  input  axi_adapter_pkg::addr_t araddr_i,
  input  logic [7:0]             arlen_i,
  input  axi_adapter_pkg::id_t   arid_i,
  output logic                   rvalid_o,
  input  logic                   rready_i,
  output axi_adapter_pkg::word_t rdata_o,
  output axi_adapter_pkg::id_t   rid_o,
  output logic                   rlast_o,
  output logic                   err_o
);
  import axi_adapter_pkg::*;

  word_t      mem [0:63];
  logic       aw_pend, w_last_seen, b_wait, bvalid_q;
  addr_t      aw_addr;
  logic [7:0] aw_len;
  id_t        aw_id;
  word_t      wbuf_data [0:3];
  strb_t      wbuf_strb [0:3];
  logic [3:0] wbuf_last;
  logic [2:0] w_cnt;
  logic       r_act, rvalid_q;
  addr_t      ar_addr;
  logic [7:0] ar_len, r_beat;
  id_t        ar_id;
  // payloads seen while a valid was stalled
  logic       aw_hold, w_hold, ar_hold;
  addr_t      aw_addr_h, ar_addr_h;
  word_t      w_data_h;
  strb_t      w_strb_h;

  initial begin
    for (int i = 0; i < 64; i++) begin
      mem[i] = {32'(i * 8) ^ 32'h5a5a_a5a5, 32'(i * 8)};
    end
  end

  assign awready_o = !stall_i[0] && !aw_pend && !b_wait;
  assign wready_o  = !stall_i[1] && !w_last_seen && !b_wait;
  assign bvalid_o  = bvalid_q;
  assign bid_o     = aw_id;
  assign arready_o = !stall_i[3] && !r_act;
  assign rvalid_o  = rvalid_q;
  assign rdata_o   = mem[6'(ar_addr[8:3]) + r_beat[5:0]];
  assign rid_o     = ar_id;
  assign rlast_o   = (r_beat == ar_len);

  task automatic flag(input string msg);
    $display("AXI protocol error at %0t: %s", $time, msg);
    err_o <= 1'b1;
  endtask

  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      aw_pend     <= 1'b0;
      w_last_seen <= 1'b0;
      b_wait      <= 1'b0;
      bvalid_q    <= 1'b0;
      w_cnt       <= '0;
      r_act       <= 1'b0;
      rvalid_q    <= 1'b0;
      r_beat      <= '0;
      aw_hold     <= 1'b0;
      w_hold      <= 1'b0;
      ar_hold     <= 1'b0;
      err_o       <= 1'b0;
    end else begin
      // ------------------------------
      // valid and payload stability
      // ------------------------------
      if (aw_hold && (!awvalid_i || awaddr_i != aw_addr_h)) flag("AW changed before transfer");
      if (w_hold && (!wvalid_i || wdata_i != w_data_h || wstrb_i != w_strb_h)) begin
        flag("W changed before transfer");
      end
      if (ar_hold && (!arvalid_i || araddr_i != ar_addr_h)) flag("AR changed before transfer");
      aw_hold   <= awvalid_i && !awready_o;
      w_hold    <= wvalid_i && !wready_o;
      ar_hold   <= arvalid_i && !arready_o;
      aw_addr_h <= awaddr_i;
      w_data_h  <= wdata_i;
      w_strb_h  <= wstrb_i;
      ar_addr_h <= araddr_i;

      // ------------------------------
      // write side
      // ------------------------------
      if (awvalid_i && awready_o) begin
        aw_pend <= 1'b1;
        aw_addr <= awaddr_i;
        aw_len  <= awlen_i;
        aw_id   <= awid_i;
      end
      if (wvalid_i && wready_o) begin
        if (w_cnt == 3'd4) flag("more than four W beats");
        wbuf_data[w_cnt[1:0]] <= wdata_i;
        wbuf_strb[w_cnt[1:0]] <= wstrb_i;
        wbuf_last[w_cnt[1:0]] <= wlast_i;
        w_cnt <= w_cnt + 3'd1;
        if (wlast_i) w_last_seen <= 1'b1;
      end
      if (aw_pend && w_last_seen) begin
        if (8'(w_cnt) != aw_len + 8'd1) flag("W beat count differs from awlen");
        for (int i = 0; i < 4; i++) begin
          if (i < int'(w_cnt)) begin
            if (wbuf_last[i] != (i == int'(w_cnt) - 1)) flag("wlast on the wrong beat");
            for (int b = 0; b < 8; b++) begin
              if (wbuf_strb[i][b]) begin
                mem[6'(aw_addr[8:3]) + 6'(i)][8*b +: 8] <= wbuf_data[i][8*b +: 8];
              end
            end
          end
        end
        aw_pend     <= 1'b0;
        w_last_seen <= 1'b0;
        w_cnt       <= '0;
        b_wait      <= 1'b1;
      end
      if (b_wait && !bvalid_q && !stall_i[2]) bvalid_q <= 1'b1;
      if (bvalid_q && bready_i) begin
        bvalid_q <= 1'b0;
        b_wait   <= 1'b0;
      end

      // ------------------------------
      // read side
      // ------------------------------
      if (arvalid_i && arready_o) begin
        r_act   <= 1'b1;
        ar_addr <= araddr_i;
        ar_len  <= arlen_i;
        ar_id   <= arid_i;
        r_beat  <= '0;
      end
      if (r_act && !rvalid_q && !stall_i[4]) rvalid_q <= 1'b1;
      if (rvalid_q && rready_i) begin
        rvalid_q <= 1'b0;
        r_beat   <= r_beat + 8'd1;
        if (r_beat == ar_len) r_act <= 1'b0;
      end
    end
  end

endmodule

/* tb/tb_axi_cache_adapter.sv */
// random single and line requests against a 512-byte memory window
// the slave stalls every channel at random and checks AXI stability
`timescale 1ns/1ps

module tb_axi_cache_adapter;
  import axi_adapter_pkg::*;

  localparam int NUM_REQ    = 200;
  localparam int MAX_CYCLES = NUM_REQ * 40;

  logic clk_i, rst_ni, req_i, we_i, gnt_o, valid_o, critical_word_valid_o;
  req_kind_e  kind_i;
  addr_t      addr_i, awaddr, araddr;
  line_t      wdata_i, rdata_o;
  line_strb_t be_i;
  logic [1:0] size_i;
  id_t        id_i, id_o, awid, bid, arid, rid;
  word_t      critical_word_o, wdata, rdata;
  strb_t      wstrb;
  logic [7:0] awlen, arlen;
  logic [2:0] awsize, arsize;
  logic [1:0] awburst, arburst;
  logic awvalid, awready, wvalid, wready, wlast, bvalid, bready;
  logic arvalid, arready, rvalid, rready, rlast, slave_err;
  logic [4:0] stall;

  logic [31:0] stim_seed, stall_seed;
  word_t       ref_mem [0:63];
  int          cycles, gnt_cnt, valid_cnt, cw_cnt, w_beats;
  logic        rlast_seen;

  axi_cache_adapter dut_i (
    .clk_i, .rst_ni, .req_i, .kind_i, .addr_i, .we_i, .wdata_i, .be_i, .size_i, .id_i,
    .gnt_o, .valid_o, .rdata_o, .id_o, .critical_word_o, .critical_word_valid_o,
    .awvalid_o(awvalid), .awready_i(awready), .awaddr_o(awaddr), .awlen_o(awlen),
    .awsize_o(awsize), .awburst_o(awburst), .awid_o(awid),
    .wvalid_o(wvalid), .wready_i(wready), .wdata_o(wdata), .wstrb_o(wstrb), .wlast_o(wlast),
    .bvalid_i(bvalid), .bid_i(bid), .bready_o(bready),
    .arvalid_o(arvalid), .arready_i(arready), .araddr_o(araddr), .arlen_o(arlen),
    .arsize_o(arsize), .arburst_o(arburst), .arid_o(arid),
    .rvalid_i(rvalid), .rdata_i(rdata), .rid_i(rid), .rlast_i(rlast), .rready_o(rready)
  );

  axi_mem_slave u_slave (
    .clk_i, .rst_ni, .stall_i(stall),
    .awvalid_i(awvalid), .awready_o(awready), .awaddr_i(awaddr), .awlen_i(awlen),
    .awid_i(awid), .wvalid_i(wvalid), .wready_o(wready), .wdata_i(wdata), .wstrb_i(wstrb),
    .wlast_i(wlast), .bvalid_o(bvalid), .bready_i(bready), .bid_o(bid),
    .arvalid_i(arvalid), .arready_o(arready), .araddr_i(araddr), .arlen_i(arlen),
    .arid_i(arid), .rvalid_o(rvalid), .rready_i(rready), .rdata_o(rdata), .rid_o(rid),
    .rlast_o(rlast), .err_o(slave_err)
  );

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [31:0] rand32();
    stim_seed = lcg_next(stim_seed);
    return stim_seed;
  endfunction

  task automatic fail_now(input string msg);
    $display("%s", msg);
    $display("Simulation failed");
    $fatal(1);
  endtask

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  // ------------------------------
  // stalls and timeout
  // ------------------------------
  always @(posedge clk_i) begin
    cycles = cycles + 1;
    if (cycles > MAX_CYCLES) fail_now("Timeout: the DUT stopped making progress");
    #1;
    stall_seed = lcg_next(stall_seed);
    stall = stall_seed[20:16] & stall_seed[25:21];
  end

  // ------------------------------
  // per-cycle protocol checks
  // ------------------------------
  always @(negedge clk_i) begin
    assert (!slave_err) else fail_now("The AXI slave reported a protocol error");
    if (rlast_seen) begin
      assert (valid_o) else fail_now($sformatf("Mismatch at %0t: no valid_o after rlast", $time));
    end
    rlast_seen = rvalid && rready && rlast;
    if (gnt_o) gnt_cnt++;
    if (valid_o) valid_cnt++;
    if (awvalid) begin
      assert (awburst == 2'b01 && awlen == ((kind_i == REQ_LINE) ? 8'd3 : 8'd0)
              && awsize == ((kind_i == REQ_LINE) ? 3'd3 : {1'b0, size_i})
              && (kind_i != REQ_LINE || awaddr[4:0] == 5'd0))
        else fail_now($sformatf("Mismatch at %0t: bad AW fields", $time));
    end
    if (arvalid) begin
      assert (arburst == 2'b01 && arlen == ((kind_i == REQ_LINE) ? 8'd3 : 8'd0)
              && arsize == ((kind_i == REQ_LINE) ? 3'd3 : {1'b0, size_i})
              && (kind_i != REQ_LINE || araddr[4:0] == 5'd0))
        else fail_now($sformatf("Mismatch at %0t: bad AR fields", $time));
    end
    if (wvalid && wready) begin
      assert (wdata == wdata_i[w_beats] && wstrb == be_i[w_beats]
              && wlast == (kind_i != REQ_LINE || w_beats == 3))
        else fail_now($sformatf("Mismatch at %0t: W beat %0d wrong", $time, w_beats));
      w_beats++;
    end
    if (critical_word_valid_o) begin
      cw_cnt++;
      assert (!we_i && kind_i == REQ_LINE && !valid_o
              && critical_word_o == ref_mem[{addr_i[8:5], addr_i[4:3]}])
        else fail_now($sformatf("Mismatch at %0t: critical word wrong", $time));
    end
  end

  task automatic run_request(input logic we, input req_kind_e kind, input addr_t addr,
                             input id_t id, input logic [1:0] size);
    logic [5:0] idx;
    idx = addr[8:3];
    for (int w = 0; w < 4; w++) begin
      wdata_i[w] = {rand32(), rand32()};
    end
    be_i = {rand32()};
    we_i = we;
    kind_i = kind;
    addr_i = addr;
    id_i = id;
    size_i = size;
    gnt_cnt = 0;
    valid_cnt = 0;
    cw_cnt = 0;
    w_beats = 0;
    req_i = 1'b1;
    do @(negedge clk_i); while (!gnt_o);
    @(posedge clk_i);
    #1;
    req_i = 1'b0;
    do @(negedge clk_i); while (!valid_o);
    assert (id_o == id) else fail_now($sformatf("Mismatch at %0t: id_o %0h", $time, id_o));
    if (!we && kind == REQ_LINE) begin
      for (int w = 0; w < 4; w++) begin
        assert (rdata_o[w] == ref_mem[{idx[5:2], 2'(w)}])
          else fail_now($sformatf("Mismatch at %0t: line word %0d", $time, w));
      end
      assert (cw_cnt == 1) else fail_now($sformatf("Mismatch at %0t: %0d strobes", $time, cw_cnt));
    end else if (!we) begin
      assert (rdata_o[0] == ref_mem[idx])
        else fail_now($sformatf("Mismatch at %0t: read word at %0h", $time, addr));
    end else begin
      for (int w = 0; w < ((kind == REQ_LINE) ? 4 : 1); w++) begin
        for (int b = 0; b < 8; b++) begin
          if (be_i[w][b]) begin
            if (kind == REQ_LINE) ref_mem[{idx[5:2], 2'(w)}][8*b +: 8] = wdata_i[w][8*b +: 8];
            else ref_mem[idx][8*b +: 8] = wdata_i[0][8*b +: 8];
          end
        end
      end
      for (int i = 0; i < 64; i++) begin
        assert (u_slave.mem[i] == ref_mem[i])
          else fail_now($sformatf("Mismatch at %0t: memory word %0d", $time, i));
      end
    end
    @(negedge clk_i);
    assert (!valid_o && gnt_cnt == 1 && valid_cnt == 1)
      else fail_now($sformatf("Mismatch at %0t: %0d grants, %0d valids", $time, gnt_cnt,
                              valid_cnt));
    @(posedge clk_i);
    #1;
  endtask

  initial begin
    logic [31:0] r;
    stim_seed = 32'd42878;
    stall_seed = lcg_next(32'd42878);
    stall = '0;
    cycles = 0;
    rlast_seen = 1'b0;
    rst_ni = 1'b0;
    req_i = 1'b0;
    we_i = 1'b0;
    kind_i = REQ_SINGLE;
    addr_i = '0;
    wdata_i = '0;
    be_i = '0;
    size_i = 2'b11;
    id_i = '0;
    for (int i = 0; i < 64; i++) begin
      ref_mem[i] = {32'(i * 8) ^ 32'h5a5a_a5a5, 32'(i * 8)};
    end
    repeat (3) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    repeat (3) begin
      @(negedge clk_i);
      assert (!gnt_o && !valid_o && !critical_word_valid_o && !awvalid && !wvalid
              && !arvalid && !bready && !rready)
        else fail_now("An output was high after reset with no request");
    end
    @(posedge clk_i);
    #1;
    for (int n = 0; n < NUM_REQ; n++) begin
      r = rand32();
      run_request(r[0], req_kind_e'(r[1]), addr_t'({r[13:8], 3'b000}), id_t'(r[19:16]),
                  r[21:20]);
    end
    $display("Simulation completed successfully");
    $finish;
  end

endmodule

/* axi_cache_adapter.f */
hdl/axi_adapter_pkg.sv
hdl/axi_line_writer.sv
hdl/axi_line_reader.sv
hdl/axi_cache_adapter.sv
tb/axi_mem_slave.sv
tb/tb_axi_cache_adapter.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --top-module tb_axi_cache_adapter \
  -f axi_cache_adapter.f \
  -o sim_axi_cache_adapter

# tee keeps the log even when the simulation stops early
./obj_dir/sim_axi_cache_adapter 2>&1 | tee sim.log

if grep -q "Simulation failed" sim.log; then
  echo "run_sim: FAIL"
  exit 1
fi
if ! grep -q "Simulation completed successfully" sim.log; then
  echo "run_sim: no result found in sim.log"
  exit 1
fi
echo "run_sim: PASS"
